// File: src/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path and address width
`define CORE_XLEN 64

// first fetch address after reset
`define CORE_RESET_PC 64'h0000_0000_0000_0000

// data memory holds 2**CORE_DMEM_AW doublewords
// indexed by address bits [CORE_DMEM_AW+2:3]
`define CORE_DMEM_AW 8

// addi x0, x0, 0
// fills flushed slots and unused instruction memory
`define CORE_NOP 32'h0000_0013

`endif

// File: src/core_pkg.sv
`default_nettype none
`include "core_defs.svh"

package core_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL,
        PASS_B
    } alu_op_e;

    // fetch to decode
    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        logic [31:0]           instr;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        logic [31:0]           instr;
        opcode_e               opcode;
        alu_op_e               alu_op;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [4:0]            rd;
        logic                  uses_rs1;
        logic                  uses_rs2;
        logic                  use_imm;
        logic [`CORE_XLEN-1:0] a;
        logic [`CORE_XLEN-1:0] b;
        logic [`CORE_XLEN-1:0] imm;
        logic                  branch_ne;
        logic                  is_load;
        logic                  is_store;
        logic                  is_jump;
        logic                  is_branch;
        logic                  is_halt;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        logic [31:0]           instr;
        logic [4:0]            rd;
        logic                  reg_we;
        logic                  is_load;
        logic                  is_store;
        logic                  is_halt;
        logic [`CORE_XLEN-1:0] result;
        logic [`CORE_XLEN-1:0] store_data;
    } ex_mem_t;

    // memory to writeback, also the retire report
    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [31:0]           instr;
        logic [4:0]            rd;
        logic                  reg_we;
        logic [`CORE_XLEN-1:0] data;
    } retire_t;

    // later-stage result offered to execute
    typedef struct packed {
        logic                  valid;
        logic [4:0]            rd;
        logic [`CORE_XLEN-1:0] data;
    } fwd_t;

endpackage

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module fetch_stage (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   load_stall_i,
    input  wire                   redirect_i,
    input  wire  [`CORE_XLEN-1:0] redirect_pc_i,
    output logic [`CORE_XLEN-1:0] imem_addr_o,
    input  wire  [31:0]           imem_data_i,
    output core_pkg::if_id_t      if_id_o
);

    logic [`CORE_XLEN-1:0] pc_q;

    // instruction memory answers in the same cycle
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q    <= `CORE_RESET_PC;
            if_id_o <= '{valid: 1'b0, pc: `CORE_RESET_PC, instr: `CORE_NOP};
        end else if (redirect_i) begin
            // drop the word fetched on the wrong path
            pc_q    <= redirect_pc_i;
            if_id_o <= '{valid: 1'b0, pc: pc_q, instr: `CORE_NOP};
        end else if (!load_stall_i) begin
            pc_q    <= pc_q + `CORE_XLEN'(4);
            if_id_o <= '{valid: 1'b1, pc: pc_q, instr: imem_data_i};
        end
        // on a load stall both pc and the decode slot hold
    end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module reg_file (
    input  wire                   clk,
    input  wire  [4:0]            rs1_i,
    input  wire  [4:0]            rs2_i,
    output logic [`CORE_XLEN-1:0] rs1_data_o,
    output logic [`CORE_XLEN-1:0] rs2_data_o,
    input  wire  core_pkg::retire_t wb_i
);

    // x0 has no storage
    logic [`CORE_XLEN-1:0] regs [31:1];

    // x0 reads zero, a same-cycle write is passed through
    function automatic logic [`CORE_XLEN-1:0] read_port(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end
        if (wb_i.reg_we && wb_i.rd == idx) begin
            return wb_i.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

    always_ff @(posedge clk) begin
        if (wb_i.reg_we && wb_i.rd != 5'd0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module decode_stage (
    input  wire                     clk,
    input  wire                     rst,
    input  wire  core_pkg::if_id_t  if_id_i,
    input  wire                     redirect_i,
    output logic [4:0]              rs1_o,
    output logic [4:0]              rs2_o,
    input  wire  [`CORE_XLEN-1:0]   rs1_data_i,
    input  wire  [`CORE_XLEN-1:0]   rs2_data_i,
    output logic                    load_stall_o,
    output core_pkg::id_ex_t        id_ex_o
);
    import core_pkg::*;

    localparam logic [31:0] EBREAK = 32'h0010_0073;

    logic [31:0]           instr;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_s;
    logic [`CORE_XLEN-1:0] imm_b;
    logic [`CORE_XLEN-1:0] imm_u;
    logic [`CORE_XLEN-1:0] imm_j;
    id_ex_t                dec;
    id_ex_t                bubble;

    // funct3 selects the operation, sub only for register-register
    function automatic alu_op_e alu_from_funct(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  return sub ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b100:  return XOR;
            3'b101:  return SRL;
            3'b110:  return OR;
            3'b111:  return AND;
            default: return ADD;
        endcase
    endfunction

    assign instr = if_id_i.instr;
    assign rs1_o = instr[19:15];
    assign rs2_o = instr[24:20];

    // sign-extended immediates per format
    assign imm_i = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`CORE_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`CORE_XLEN-13){instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{(`CORE_XLEN-32){instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{(`CORE_XLEN-21){instr[31]}}, instr[31], instr[19:12],
                    instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec          = '0;
        dec.valid    = if_id_i.valid;
        dec.pc       = if_id_i.pc;
        dec.instr    = instr;
        dec.opcode   = opcode_e'(instr[6:0]);
        dec.alu_op   = ADD;
        dec.rs1      = rs1_o;
        dec.rs2      = rs2_o;
        dec.rd       = instr[11:7];
        dec.a        = rs1_data_i;
        dec.b        = rs2_data_i;
        case (dec.opcode)
            OP: begin
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.alu_op   = alu_from_funct(instr[14:12], instr[30]);
            end
            OP_IMM: begin
                dec.uses_rs1 = 1'b1;
                dec.use_imm  = 1'b1;
                dec.imm      = imm_i;
                dec.alu_op   = alu_from_funct(instr[14:12], 1'b0);
            end
            LUI: begin
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.alu_op  = PASS_B;
            end
            LOAD: begin
                dec.uses_rs1 = 1'b1;
                dec.use_imm  = 1'b1;
                dec.imm      = imm_i;
                dec.is_load  = 1'b1;
            end
            STORE: begin
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.use_imm  = 1'b1;
                dec.imm      = imm_s;
                dec.is_store = 1'b1;
            end
            BRANCH: begin
                dec.uses_rs1  = 1'b1;
                dec.uses_rs2  = 1'b1;
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                // funct3 000 is beq, 001 is bne
                dec.branch_ne = instr[12];
            end
            JAL: begin
                dec.imm     = imm_j;
                dec.is_jump = 1'b1;
            end
            SYSTEM: begin
                dec.is_halt = (instr == EBREAK);
            end
            default: ;
        endcase
    end

    // load result arrives one stage too late for the next instruction
    assign load_stall_o = if_id_i.valid && id_ex_o.valid && id_ex_o.is_load
                          && id_ex_o.rd != 5'd0
                          && ((dec.uses_rs1 && dec.rs1 == id_ex_o.rd)
                              || (dec.uses_rs2 && dec.rs2 == id_ex_o.rd));

    always_comb begin
        bubble       = '0;
        bubble.instr = `CORE_NOP;
    end

    always_ff @(posedge clk) begin
        if (rst || redirect_i || load_stall_o) begin
            id_ex_o <= bubble;
        end else begin
            id_ex_o <= dec;
        end
    end

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module execute_stage (
    input  wire                     clk,
    input  wire                     rst,
    input  wire  core_pkg::id_ex_t  id_ex_i,
    input  wire  core_pkg::fwd_t    mem_fwd_i,
    output core_pkg::fwd_t          ex_fwd_o,
    output logic                    redirect_o,
    output logic [`CORE_XLEN-1:0]   redirect_pc_o,
    output core_pkg::ex_mem_t       ex_mem_o
);
    import core_pkg::*;

    logic [`CORE_XLEN-1:0] rs1_val;
    logic [`CORE_XLEN-1:0] rs2_val;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] alu_res;
    logic [`CORE_XLEN-1:0] link_pc;
    logic                  taken;
    logic                  writes_rd;
    ex_mem_t               next;

    // nearest producer wins, else the value read in decode
    function automatic logic [`CORE_XLEN-1:0] pick_operand(
        input logic [4:0]            idx,
        input logic [`CORE_XLEN-1:0] decoded,
        input fwd_t                  near,
        input fwd_t                  far
    );
        if (near.valid && near.rd == idx) begin
            return near.data;
        end
        if (far.valid && far.rd == idx) begin
            return far.data;
        end
        return decoded;
    endfunction

    // result of the previous instruction, loads excluded since they stall in decode
    always_comb begin
        ex_fwd_o.valid = ex_mem_o.valid && ex_mem_o.reg_we && !ex_mem_o.is_load
                         && ex_mem_o.rd != 5'd0;
        ex_fwd_o.rd    = ex_mem_o.rd;
        ex_fwd_o.data  = ex_mem_o.result;
    end

    always_comb begin
        rs1_val = pick_operand(id_ex_i.rs1, id_ex_i.a, ex_fwd_o, mem_fwd_i);
        rs2_val = pick_operand(id_ex_i.rs2, id_ex_i.b, ex_fwd_o, mem_fwd_i);
    end

    assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;
    assign link_pc = id_ex_i.pc + `CORE_XLEN'(4);

    always_comb begin
        case (id_ex_i.alu_op)
            ADD:     alu_res = rs1_val + op_b;
            SUB:     alu_res = rs1_val - op_b;
            AND:     alu_res = rs1_val & op_b;
            OR:      alu_res = rs1_val | op_b;
            XOR:     alu_res = rs1_val ^ op_b;
            SLT:     alu_res = `CORE_XLEN'($signed(rs1_val) < $signed(op_b));
            SLL:     alu_res = rs1_val << op_b[5:0];
            SRL:     alu_res = rs1_val >> op_b[5:0];
            PASS_B:  alu_res = op_b;
            default: alu_res = '0;
        endcase
    end

    // beq and bne compare the forwarded register values
    assign taken = id_ex_i.is_branch && (id_ex_i.branch_ne ^ (rs1_val == rs2_val));

    assign redirect_o    = id_ex_i.valid && (taken || id_ex_i.is_jump);
    assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

    assign writes_rd = id_ex_i.opcode inside {OP, OP_IMM, LUI, LOAD, JAL};

    always_comb begin
        next            = '0;
        next.valid      = id_ex_i.valid;
        next.pc         = id_ex_i.pc;
        next.instr      = id_ex_i.instr;
        next.rd         = id_ex_i.rd;
        next.reg_we     = id_ex_i.valid && writes_rd;
        next.is_load    = id_ex_i.is_load;
        next.is_store   = id_ex_i.is_store;
        next.is_halt    = id_ex_i.is_halt;
        next.result     = id_ex_i.is_jump ? link_pc : alu_res;
        next.store_data = rs2_val;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o <= next;
        end
    end

endmodule

`default_nettype wire

// File: src/memory_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module memory_stage #(
    parameter int DMEM_AW = `CORE_DMEM_AW
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire  core_pkg::ex_mem_t ex_mem_i,
    output core_pkg::fwd_t          mem_fwd_o,
    output core_pkg::retire_t       retire_o,
    output logic                    retire_valid_o,
    output logic                    halt_o
);

    logic [`CORE_XLEN-1:0] dmem [0:(1<<DMEM_AW)-1];
    logic [DMEM_AW-1:0]    dmem_idx;
    logic [`CORE_XLEN-1:0] load_data;
    logic [`CORE_XLEN-1:0] wb_data;
    logic                  live;

    // nothing past an ebreak takes effect
    assign live = ex_mem_i.valid && !halt_o;

    // doubleword index, low three address bits ignored
    assign dmem_idx  = ex_mem_i.result[DMEM_AW+2:3];
    assign load_data = dmem[dmem_idx];
    assign wb_data   = ex_mem_i.is_load ? load_data : ex_mem_i.result;

    always_ff @(posedge clk) begin
        if (live && ex_mem_i.is_store) begin
            dmem[dmem_idx] <= ex_mem_i.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_o       <= '0;
            retire_valid_o <= 1'b0;
            halt_o         <= 1'b0;
        end else begin
            retire_o.pc     <= ex_mem_i.pc;
            retire_o.instr  <= ex_mem_i.instr;
            retire_o.rd     <= ex_mem_i.rd;
            retire_o.reg_we <= live && ex_mem_i.reg_we;
            retire_o.data   <= wb_data;
            retire_valid_o  <= live;
            // sticky until reset
            if (live && ex_mem_i.is_halt) begin
                halt_o <= 1'b1;
            end
        end
    end

    // writeback value, two instructions ahead of execute
    always_comb begin
        mem_fwd_o.valid = retire_valid_o && retire_o.reg_we && retire_o.rd != 5'd0;
        mem_fwd_o.rd    = retire_o.rd;
        mem_fwd_o.data  = retire_o.data;
    end

endmodule

`default_nettype wire

// File: src/core_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module core_top #(
    parameter int DMEM_AW = `CORE_DMEM_AW
) (
    input  wire                   clk,
    input  wire                   rst,
    output logic [`CORE_XLEN-1:0] imem_addr_o,
    input  wire  [31:0]           imem_data_i,
    output logic                  retire_valid_o,
    output core_pkg::retire_t     retire_o,
    output logic                  halt_o
);
    import core_pkg::*;

    if_id_t                if_id;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    fwd_t                  mem_fwd;
    logic                  load_stall;
    logic                  redirect;
    logic [`CORE_XLEN-1:0] redirect_pc;
    logic [4:0]            rs1_idx;
    logic [4:0]            rs2_idx;
    logic [`CORE_XLEN-1:0] rs1_data;
    logic [`CORE_XLEN-1:0] rs2_data;

    fetch_stage u_fetch (
        .clk           (clk),
        .rst           (rst),
        .load_stall_i  (load_stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_addr_o   (imem_addr_o),
        .imem_data_i   (imem_data_i),
        .if_id_o       (if_id)
    );

    decode_stage u_decode (
        .clk          (clk),
        .rst          (rst),
        .if_id_i      (if_id),
        .redirect_i   (redirect),
        .rs1_o        (rs1_idx),
        .rs2_o        (rs2_idx),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .load_stall_o (load_stall),
        .id_ex_o      (id_ex)
    );

    // writes come from the retire record
    reg_file u_regs (
        .clk        (clk),
        .rs1_i      (rs1_idx),
        .rs2_i      (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (retire_o)
    );

    // execute forward loops back inside the stage
    execute_stage u_execute (
        .clk           (clk),
        .rst           (rst),
        .id_ex_i       (id_ex),
        .mem_fwd_i     (mem_fwd),
        .ex_fwd_o      (),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .ex_mem_o      (ex_mem)
    );

    memory_stage #(
        .DMEM_AW (DMEM_AW)
    ) u_memory (
        .clk            (clk),
        .rst            (rst),
        .ex_mem_i       (ex_mem),
        .mem_fwd_o      (mem_fwd),
        .retire_o       (retire_o),
        .retire_valid_o (retire_valid_o),
        .halt_o         (halt_o)
    );

endmodule

`default_nettype wire

// File: testbench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int          PROG_LEN    = 200;
localparam int          INIT_LEN    = 31;
localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

logic [31:0]           prog [0:PROG_LEN-1];
logic [`CORE_XLEN-1:0] model_regs [0:31];
logic [`CORE_XLEN-1:0] model_mem [0:(1<<`CORE_DMEM_AW)-1];
logic [`CORE_XLEN-1:0] model_pc;
logic                  model_done;

// anything past the program reads as a nop
function automatic logic [31:0] fetch_word(input logic [`CORE_XLEN-1:0] addr);
    if (addr >= 64'(PROG_LEN * 4)) begin
        return `CORE_NOP;
    end
    return prog[addr[9:2]];
endfunction

function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic sub,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

// sd only, funct3 011
function automatic logic [31:0] enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                      input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// half the time reuse the last destination
function automatic logic [4:0] pick_src(input logic [4:0] prev_rd);
    return ($urandom % 2 == 0) ? prev_rd : 5'($urandom % 32);
endfunction

task automatic gen_program();
    int          i;
    int          kind;
    int          hop;
    int          shadow_end;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  prev_rd;
    logic [11:0] off;
    logic [2:0]  f3;
    logic [11:0] stored [$];
    shadow_end = 0;
    prev_rd    = 5'd1;
    // every register gets a defined value first
    for (i = 1; i <= INIT_LEN; i++) begin
        if (i % 2 == 1) begin
            prog[i-1] = {20'($urandom), 5'(i), 7'b0110111};
        end else begin
            prog[i-1] = enc_i(7'b0010011, 3'b000, 5'(i), 5'd0, 12'($urandom));
        end
    end
    for (i = INIT_LEN; i < PROG_LEN - 1; i++) begin
        kind = $urandom % 16;
        rd   = ($urandom % 16 == 0) ? 5'd0 : 5'(1 + $urandom % 31);
        rs1  = pick_src(prev_rd);
        rs2  = pick_src(prev_rd);
        hop  = 2 + $urandom % 3;
        if (hop > PROG_LEN - 1 - i) begin
            hop = PROG_LEN - 1 - i;
        end
        // no room for a forward jump near the end, or nothing stored yet
        if ((kind >= 13 && hop < 2) || (kind inside {11, 12} && stored.size() == 0)) begin
            kind = 5;
        end
        case (kind)
            0, 1, 2, 3, 4: begin
                // skip funct3 011, sltu is not in the subset
                f3 = 3'($urandom % 7);
                if (f3 >= 3'd3) begin
                    f3 = f3 + 3'd1;
                end
                prog[i] = enc_r(f3, f3 == 3'b000 && $urandom % 2 == 1, rd, rs1, rs2);
            end
            5, 6, 7: begin
                case ($urandom % 4)
                    0:       f3 = 3'b000;
                    1:       f3 = 3'b100;
                    2:       f3 = 3'b110;
                    default: f3 = 3'b111;
                endcase
                prog[i] = enc_i(7'b0010011, f3, rd, rs1, 12'($urandom));
            end
            8: prog[i] = {20'($urandom), rd, 7'b0110111};
            9, 10: begin
                off     = 12'(8 * ($urandom % 256));
                prog[i] = enc_s(5'd0, rs2, off);
                // a store that may be jumped over does not count
                if (i >= shadow_end) begin
                    stored.push_back(off);
                end
            end
            11, 12: begin
                off     = stored[$urandom % stored.size()];
                prog[i] = enc_i(7'b0000011, 3'b011, rd, 5'd0, off);
            end
            13, 14: begin
                if ($urandom % 2 == 1) begin
                    rs2 = rs1;
                end
                prog[i] = enc_b(3'($urandom % 2), rs1, rs2, 13'(hop * 4));
            end
            default: prog[i] = enc_j(rd, 21'(hop * 4));
        endcase
        if (kind >= 13 && i + hop > shadow_end) begin
            shadow_end = i + hop;
        end
        if (!(kind inside {9, 10, 13, 14})) begin
            prev_rd = rd;
        end
    end
    prog[PROG_LEN-1] = EBREAK_WORD;
endtask

// one instruction on the model state, returns what should retire
function automatic core_pkg::retire_t step_model();
    core_pkg::retire_t     rec;
    logic [31:0]           ins;
    logic [`CORE_XLEN-1:0] a;
    logic [`CORE_XLEN-1:0] b;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] addr;
    logic [`CORE_XLEN-1:0] res;
    logic [`CORE_XLEN-1:0] next_pc;
    ins     = fetch_word(model_pc);
    a       = model_regs[ins[19:15]];
    b       = model_regs[ins[24:20]];
    imm_i   = {{52{ins[31]}}, ins[31:20]};
    res     = '0;
    next_pc = model_pc + 64'd4;
    rec     = '{pc: model_pc, instr: ins, rd: ins[11:7], reg_we: 1'b0, data: '0};
    case (ins[6:0])
        7'b0110011, 7'b0010011: begin
            if (ins[6:0] == 7'b0010011) begin
                b = imm_i;
            end
            case (ins[14:12])
                3'b000:  res = (ins[5] && ins[30]) ? a - b : a + b;
                3'b001:  res = a << b[5:0];
                3'b010:  res = {63'b0, $signed(a) < $signed(b)};
                3'b100:  res = a ^ b;
                3'b101:  res = a >> b[5:0];
                3'b110:  res = a | b;
                default: res = a & b;
            endcase
            rec.reg_we = 1'b1;
        end
        7'b0110111: begin
            res        = {{32{ins[31]}}, ins[31:12], 12'b0};
            rec.reg_we = 1'b1;
        end
        7'b0000011: begin
            addr       = a + imm_i;
            res        = model_mem[addr[`CORE_DMEM_AW+2:3]];
            rec.reg_we = 1'b1;
        end
        7'b0100011: begin
            addr = a + {{52{ins[31]}}, ins[31:25], ins[11:7]};
            model_mem[addr[`CORE_DMEM_AW+2:3]] = b;
        end
        7'b1100011: begin
            // funct3 bit 0 clear is beq, set is bne
            if ((ins[12] == 1'b0) == (a == b)) begin
                next_pc = model_pc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25],
                                      ins[11:8], 1'b0};
            end
        end
        7'b1101111: begin
            res        = model_pc + 64'd4;
            rec.reg_we = 1'b1;
            next_pc    = model_pc + {{43{ins[31]}}, ins[31], ins[19:12], ins[20],
                                     ins[30:21], 1'b0};
        end
        default: begin
            if (ins == EBREAK_WORD) begin
                model_done = 1'b1;
            end
        end
    endcase
    if (rec.reg_we && rec.rd != 5'd0) begin
        model_regs[rec.rd] = res;
    end
    rec.data = res;
    model_pc = next_pc;
    return rec;
endfunction

`endif

// File: testbench/tb_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_defs.svh"

module tb_core;
    import core_pkg::*;

    localparam time         CLK_PERIOD   = 100;
    localparam time         DRIVE_DLY    = 5;
    localparam int          RESET_CYCLES = 3;
    localparam logic [31:0] SEED         = 32'ha6eaf51b;

    logic                  clk;
    logic                  rst;
    logic [`CORE_XLEN-1:0] imem_addr;
    logic [31:0]           imem_data;
    logic                  retire_valid;
    retire_t               retire;
    logic                  halt;

    retire_t               expected_q [$];
    retire_t               exp_rec;
    int                    expected_total;
    int                    retire_count;
    logic                  ebreak_seen;

    `include "tb_program.svh"

    core_top uut (
        .clk            (clk),
        .rst            (rst),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .retire_valid_o (retire_valid),
        .retire_o       (retire),
        .halt_o         (halt)
    );

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // run the reference over the whole program up front
    task automatic build_expected();
        int r;
        int steps;
        model_pc   = `CORE_RESET_PC;
        model_done = 1'b0;
        steps      = 0;
        for (r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        while (!model_done && steps < 4 * PROG_LEN) begin
            expected_q.push_back(step_model());
            steps++;
        end
        if (!model_done) begin
            $display("Error: the reference model never reached ebreak");
            $display("** FAIL **");
            $fatal(1, "reference model did not finish");
        end
        expected_total = expected_q.size();
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // instruction memory, refreshed just after the pc moves
    initial begin
        imem_data = `CORE_NOP;
        forever begin
            @(posedge clk);
            #(DRIVE_DLY);
            imem_data = fetch_word(imem_addr);
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            check_value("retire_valid_o in reset", 64'(retire_valid), 64'd0);
            check_value("halt_o in reset", 64'(halt), 64'd0);
        end else begin
            if (retire_valid && expected_q.size() == 0) begin
                $display("Error at %0t: pc %h retired after the last expected instruction",
                         $time, retire.pc);
                $display("** FAIL **");
                $fatal(1, "extra retirement");
            end else if (retire_valid) begin
                exp_rec      = expected_q.pop_front();
                retire_count = retire_count + 1;
                check_value($sformatf("pc of retirement %0d", retire_count),
                            retire.pc, exp_rec.pc);
                check_value($sformatf("instr at pc %h", exp_rec.pc),
                            64'(retire.instr), 64'(exp_rec.instr));
                check_value($sformatf("reg_we at pc %h", exp_rec.pc),
                            64'(retire.reg_we), 64'(exp_rec.reg_we));
                if (exp_rec.reg_we) begin
                    check_value($sformatf("rd at pc %h", exp_rec.pc),
                                64'(retire.rd), 64'(exp_rec.rd));
                end
                // data of an x0 write is never visible
                if (exp_rec.reg_we && exp_rec.rd != 5'd0) begin
                    check_value($sformatf("data at pc %h", exp_rec.pc),
                                retire.data, exp_rec.data);
                end
                if (exp_rec.instr == EBREAK_WORD) begin
                    ebreak_seen = 1'b1;
                end
            end
            check_value("halt_o", 64'(halt), 64'(ebreak_seen));
        end
    end

    initial begin
        rst          = 1'b1;
        retire_count = 0;
        ebreak_seen  = 1'b0;
        void'($urandom(SEED));
        gen_program();
        build_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DLY);
        rst = 1'b0;
        while (halt !== 1'b1) begin
            @(posedge clk);
        end
        // a few more cycles to catch anything retiring past ebreak
        repeat (10) @(posedge clk);
        if (ebreak_seen && expected_q.size() == 0 && retire_count == expected_total) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("Error: %0d of %0d expected instructions retired",
                     retire_count, expected_total);
            $display("** FAIL **");
            $fatal(1, "retire count differs from the reference model");
        end
    end

    // 20 cycles per instruction plus reset
    initial begin
        #(CLK_PERIOD * (20 * PROG_LEN + RESET_CYCLES));
        $display("Error: timed out at %0t before the core halted", $time);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+src
+incdir+testbench
src/core_pkg.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/core_top.sv
testbench/tb_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_core -o tb_core

# a failing run still leaves its log for the search below
./obj_dir/tb_core > sim.log 2>&1 || true
cat sim.log

grep -qxF '** PASS **' sim.log
